//--- flist.f
+incdir+.
rename_pkg.sv
map_table.sv
free_list.sv
rob_slot_counter.sv
rename_ctrl.sv
rename_top.sv
rename_asserts.sv
tb_clock.sv
rename_tb.sv

//--- free_list.sv
// Circular queue of free physical tags
// Pops on rename, pushes the old tag on retire
// Head checkpoint per slot so a rollback returns the tags taken after it

`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     rename_fire,
  input  logic                     dest_is_zero,
  input  logic                     event_valid,
  input  rename_pkg::rename_event_t evt,
  input  rename_pkg::slot_idx_t     tail_slot,
  output rename_pkg::phys_tag_t     free_tag,
  output logic                     free_empty
);
  import rename_pkg::*;

  // One wrap bit on top of the index tells full from empty
  localparam int PTR_W = $clog2(`RN_FREE_DEPTH) + 1;

  phys_tag_t        ring [`RN_FREE_DEPTH];
  logic [PTR_W-1:0] head_q;                  // Next tag to hand out
  logic [PTR_W-1:0] tail_q;                  // Next place for a released tag
  logic [PTR_W-1:0] head_ckpt [`RN_SLOTS];   // Head right after each rename
  logic [PTR_W-1:0] head_pop;
  logic [PTR_W-1:0] count;

  logic pop;
  logic push;
  logic rollback;

  assign pop      = rename_fire && !dest_is_zero; // Register 31 takes no tag
  assign push     = event_valid && (evt.kind == EV_RETIRE);
  assign rollback = event_valid && (evt.kind == EV_ROLLBACK);
  assign head_pop = head_q + PTR_W'(pop);

  // Count follows from the pointers, so a restored head brings the right count along
  assign count      = tail_q - head_q;
  assign free_empty = count == '0;
  assign free_tag   = ring[head_q[PTR_W-2:0]];

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q <= '0;
      tail_q <= PTR_W'(`RN_FREE_DEPTH); // Starts full
    end else begin
      if (rollback) head_q <= head_ckpt[evt.body.recover.slot];
      else          head_q <= head_pop;
      if (push)     tail_q <= tail_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
        ring[i] <= phys_tag_t'(`RN_ARCH_REGS + i); // Tags 32 to 63 in order
      end
    end else if (push) begin
      ring[tail_q[PTR_W-2:0]] <= evt.body.recover.tag;
    end
  end

  // Saved on every rename, also for register 31, so each slot has a valid head
  always_ff @(posedge clock) begin
    if (rename_fire) head_ckpt[tail_slot] <= head_pop;
  end

endmodule

//--- map_table.sv
// Architectural to physical map table with ready bits
// Combinational source and old-destination lookups with completion bypass
// One checkpoint of the map per reorder-buffer slot for rollback

`timescale 1ns/1ps
`include "rename_macros.svh"

module map_table (
  input  logic                     clock,
  input  logic                     reset,
  input  rename_pkg::rename_req_t   request,
  input  logic                     rename_fire,
  input  rename_pkg::phys_tag_t     free_tag,
  input  rename_pkg::slot_idx_t     tail_slot,
  input  logic                     event_valid,
  input  rename_pkg::rename_event_t evt,
  output rename_pkg::map_entry_t    lookup_a,
  output rename_pkg::map_entry_t    lookup_b,
  output rename_pkg::phys_tag_t     old_tag
);
  import rename_pkg::*;

  map_entry_t map_q    [`RN_ARCH_REGS]; // Live speculative map
  map_entry_t map_next [`RN_ARCH_REGS];
  phys_tag_t  ckpt     [`RN_SLOTS][`RN_ARCH_REGS]; // Tags only, ready is implied on restore
  phys_tag_t  ckpt_row [`RN_ARCH_REGS];

  logic      cmp_hit;      // Completion matches the current mapping
  arch_idx_t cmp_arch;
  logic      rollback;
  logic      dest_is_zero;

  assign cmp_arch     = evt.body.complete.arch;
  assign cmp_hit      = event_valid && (evt.kind == EV_COMPLETE) &&
                        (map_q[cmp_arch].tag == evt.body.complete.tag); // Stale tags drop out
  assign rollback     = event_valid && (evt.kind == EV_ROLLBACK);
  assign dest_is_zero = request.dest == arch_idx_t'(`RN_ZERO_REG);

  ////////////////////////////////////////////////////////////////////////////
  // Lookups
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lookup_a = map_q[request.src_a];
    lookup_b = map_q[request.src_b];
    if (cmp_hit && (cmp_arch == request.src_a)) lookup_a.ready = 1'b1; // Same-cycle completion
    if (cmp_hit && (cmp_arch == request.src_b)) lookup_b.ready = 1'b1;
    old_tag = map_q[request.dest].tag; // Released when this rename retires
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next map
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    map_next = map_q;
    if (rollback) begin
      for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        map_next[i] = '{tag: ckpt[evt.body.recover.slot][i], ready: 1'b1};
      end
    end else begin
      if (cmp_hit) map_next[cmp_arch].ready = 1'b1;
      // The rename overrides a completion of the tag it replaces
      if (rename_fire && !dest_is_zero) begin
        map_next[request.dest] = '{tag: free_tag, ready: 1'b0};
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
      ckpt_row[i] = map_next[i].tag; // Map as it stands right after this rename
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        map_q[i] <= '{tag: phys_tag_t'(i), ready: 1'b1}; // Identity map, all values present
      end
    end else begin
      map_q <= map_next;
    end
  end

  // A restored map counts everything as ready since older producers are done or in flight
  always_ff @(posedge clock) begin
    if (rename_fire) ckpt[tail_slot] <= ckpt_row;
  end

endmodule

//--- rename_asserts.sv
// Concurrent assertions for the rename stage
// Four-phase handshake rules, response stability and the rollback stall
// Bound into every rename_top instance

`timescale 1ns/1ps

module rename_asserts (
  input logic                      clock,
  input logic                      reset,
  input logic                      req,
  input logic                      ack,
  input logic                      event_valid,
  input rename_pkg::rename_rsp_t   response,
  input rename_pkg::rename_event_t evt
);
  import rename_pkg::*;

  int   fail_count = 0; // Failed assertions so far
  logic rollback;

  assign rollback = event_valid && (evt.kind == EV_ROLLBACK);

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////////////////////////////////////////

  ack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> $past(req)) // Ack only answers a sampled request
    else begin fail_count++; $error("ack rose without a pending req"); end

  ack_holds_for_req: assert property (@(posedge clock) disable iff (reset)
    ack && req |=> ack)
    else begin fail_count++; $error("ack fell while req was still high"); end

  ack_drops_after_req: assert property (@(posedge clock) disable iff (reset)
    ack && !req |=> !ack) // Ack falls on the edge after req is seen low
    else begin fail_count++; $error("ack stayed high after req fell"); end

  req_waits_for_ack_low: assert property (@(posedge clock) disable iff (reset)
    $rose(req) |-> !ack)
    else begin fail_count++; $error("req rose again while ack was high"); end

  response_stable: assert property (@(posedge clock) disable iff (reset)
    ack && $past(ack) |-> $stable(response)) // Held from the fire edge until ack falls
    else begin fail_count++; $error("response changed while ack was high"); end

  ////////////////////////////////////////////////////////////////////////////
  // Rollback
  ////////////////////////////////////////////////////////////////////////////

  no_ack_after_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback |=> !$rose(ack)) // The map is being replaced so nothing may fire
    else begin fail_count++; $error("ack rose from a rename in a rollback cycle"); end

endmodule

bind rename_top rename_asserts u_asserts (
  .clock, .reset, .req, .ack, .event_valid, .response, .evt
);

//--- rename_ctrl.sv
// Front-end handshake controller for the rename stage
// Four-phase req/ack FSM, stall decision and the registered response

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_ctrl (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req,
  input  rename_pkg::rename_req_t   request,
  input  logic                     event_valid,
  input  rename_pkg::rename_event_t evt,
  input  logic                     free_empty,
  input  logic                     slots_full,
  input  rename_pkg::map_entry_t    lookup_a,
  input  rename_pkg::map_entry_t    lookup_b,
  input  rename_pkg::phys_tag_t     old_tag,
  input  rename_pkg::phys_tag_t     free_tag,
  input  rename_pkg::slot_idx_t     tail_slot,
  output logic                     rename_fire,
  output logic                     ack,
  output rename_pkg::rename_rsp_t   response
);
  import rename_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,     // Ack low, waiting for a request that can go
    S_ACK,      // First cycle of ack with a fresh response
    S_WAIT_LOW  // Ack held until the front end drops req
  } state_e;

  state_e state_q;
  state_e state_d;

  logic rollback_now;
  logic stall;
  logic dest_is_zero;

  assign rollback_now = event_valid && (evt.kind == EV_ROLLBACK); // Map is being replaced
  assign stall        = free_empty || slots_full || rollback_now;
  assign dest_is_zero = request.dest == arch_idx_t'(`RN_ZERO_REG);

  assign rename_fire = (state_q == S_IDLE) && req && !stall; // Single cycle by construction
  assign ack         = state_q != S_IDLE;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:     if (rename_fire) state_d = S_ACK;
      S_ACK:      state_d = req ? S_WAIT_LOW : S_IDLE;
      S_WAIT_LOW: if (!req) state_d = S_IDLE;   // Ack falls on the edge that sees req low
      default:    state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) state_q <= S_IDLE;
    else       state_q <= state_d;
  end

  // Captured on the fire edge and held while ack is high
  always_ff @(posedge clock) begin
    if (rename_fire) begin
      response.src_a   <= lookup_a;
      response.src_b   <= lookup_b;
      response.old_tag <= old_tag;
      response.new_tag <= dest_is_zero ? old_tag : free_tag; // Zero register keeps its tag
      response.slot    <= tail_slot;
    end
  end

endmodule

//--- rename_macros.svh
// Sizing constants for the register-rename stage
// Register counts, physical tag count, checkpoint depth and the zero register

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Register file sizes
////////////////////////////////////////////////////////////////////////////

`define RN_ARCH_REGS 32 // Architectural registers seen by the ISA
`define RN_PHYS_REGS 64 // Physical tags behind them

// Tags beyond the identity mapping start out on the free list
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

////////////////////////////////////////////////////////////////////////////
// Speculation depth
////////////////////////////////////////////////////////////////////////////

`define RN_SLOTS 8 // Reorder-buffer slots, one map checkpoint each

`define RN_ZERO_REG 31 // Hardwired zero, never renamed and always ready

`endif

//--- rename_pkg.sv
// Shared types for the register-rename stage
// Index and tag types, map entries, request and response words, event word

`include "rename_macros.svh"

package rename_pkg;

  typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_idx_t; // Architectural register index
  typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_tag_t; // Physical register tag
  typedef logic [$clog2(`RN_SLOTS)-1:0]     slot_idx_t; // Reorder-buffer slot

  typedef struct packed {
    phys_tag_t tag;   // Physical register holding the value
    logic      ready; // Value has been produced
  } map_entry_t;

  typedef struct packed {
    arch_idx_t dest;  // Register being written
    arch_idx_t src_a; // First operand
    arch_idx_t src_b; // Second operand
  } rename_req_t;

  typedef struct packed {
    map_entry_t src_a;   // Mapping of the first operand
    map_entry_t src_b;   // Mapping of the second operand
    phys_tag_t  old_tag; // Previous mapping of the destination, freed at retire
    phys_tag_t  new_tag; // Fresh mapping of the destination
    slot_idx_t  slot;    // Reorder-buffer slot taken by this rename
  } rename_rsp_t;

  typedef enum logic [1:0] {
    EV_COMPLETE, // A producer wrote its physical register
    EV_RETIRE,   // Oldest slot leaves and its old tag is released
    EV_ROLLBACK  // Squash everything younger than a slot
  } event_kind_e;

  // Both views keep the tag in the low bits so it sits at one place
  typedef union packed {
    struct packed {
      arch_idx_t arch; // Register whose ready bit may be set
      phys_tag_t tag;  // Tag that was written
    } complete;
    struct packed {
      logic [1:0] spare; // Pads the view to the width of the complete view
      slot_idx_t  slot;  // Rollback target
      phys_tag_t  tag;   // Old tag to release on retire
    } recover;
  } event_body_u;

  typedef struct packed {
    event_kind_e kind;
    event_body_u body;
  } rename_event_t;

endpackage

//--- rename_tb.sv
// Testbench for the register-rename stage
// Reference map, free queue and slot model, directed and random stimulus, timeout

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_tb;
  import rename_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int STALL_CYCLES   = 20; // Length of the back-pressure hold
  localparam int DIRECTED_OPS   = 30;
  localparam int RANDOM_OPS     = 60;
  localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * 20 + RESET_CYCLES + STALL_CYCLES;

  logic          clock;
  logic          reset;
  logic          req;
  logic          ack;
  logic          event_valid;
  rename_req_t   request;
  rename_rsp_t   response;
  rename_event_t evt;

  phys_tag_t   ref_tag   [`RN_ARCH_REGS];            // Expected map
  logic        ref_rdy   [`RN_ARCH_REGS];
  phys_tag_t   ckpt_tag  [`RN_SLOTS][`RN_ARCH_REGS]; // Map right after each slot's rename
  phys_tag_t   slot_new  [`RN_SLOTS];
  phys_tag_t   slot_old  [`RN_SLOTS];
  logic        slot_took [`RN_SLOTS];                // Slot popped a tag from the free list
  phys_tag_t   free_q    [$];                        // Expected free tags with the oldest first
  int          ref_head;
  int          ref_tail;
  int          ref_count;
  int          n_checks    = 0;
  int          n_errors    = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr        = 32'hd8ad_dd3e;

  tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clock, .reset);

  rename_top u_dut (
    .clock, .reset, .req, .request, .ack, .response, .event_valid, .evt
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit drawn
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic rename_req_t make_req(input int dest, input int src_a, input int src_b);
    return '{dest: arch_idx_t'(dest), src_a: arch_idx_t'(src_a), src_b: arch_idx_t'(src_b)};
  endfunction

  // The index is the register for a completion and the slot otherwise
  function automatic rename_event_t make_event(input event_kind_e kind, input int idx,
                                               input phys_tag_t tag);
    rename_event_t ev;
    ev.kind = kind;
    if (kind == EV_COMPLETE) ev.body.complete = '{arch: arch_idx_t'(idx), tag: tag};
    else                     ev.body.recover  = '{spare: 2'b00, slot: slot_idx_t'(idx), tag: tag};
    return ev;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_event(input rename_event_t ev);
    int k;
    int younger;
    int s;
    k = int'(ev.body.recover.slot);
    case (ev.kind)
      EV_COMPLETE: begin
        if (ref_tag[ev.body.complete.arch] == ev.body.complete.tag) // Stale tags do nothing
          ref_rdy[ev.body.complete.arch] = 1'b1;
      end
      EV_RETIRE: begin
        free_q.push_back(ev.body.recover.tag);
        ref_head  = (ref_head + 1) % `RN_SLOTS;
        ref_count = ref_count - 1;
      end
      EV_ROLLBACK: begin
        younger = (ref_tail - k - 1 + `RN_SLOTS) % `RN_SLOTS;
        for (int i = 0; i < younger; i++) begin
          s = (ref_tail - 1 - i + `RN_SLOTS) % `RN_SLOTS; // Youngest goes back first
          if (slot_took[s]) free_q.push_front(slot_new[s]);
        end
        ref_tag = ckpt_tag[k];
        foreach (ref_rdy[r]) ref_rdy[r] = 1'b1;
        ref_tail  = (k + 1) % `RN_SLOTS;
        ref_count = ((k - ref_head + `RN_SLOTS) % `RN_SLOTS) + 1;
      end
      default: ;
    endcase
  endtask

  task automatic model_rename(input rename_req_t rq, output rename_rsp_t exp);
    exp.src_a   = '{tag: ref_tag[rq.src_a], ready: ref_rdy[rq.src_a]};
    exp.src_b   = '{tag: ref_tag[rq.src_b], ready: ref_rdy[rq.src_b]};
    exp.old_tag = ref_tag[rq.dest];
    exp.new_tag = ref_tag[rq.dest]; // Register 31 keeps its tag
    exp.slot    = slot_idx_t'(ref_tail);
    slot_took[ref_tail] = rq.dest != arch_idx_t'(`RN_ZERO_REG);
    if (slot_took[ref_tail]) begin
      exp.new_tag      = free_q.pop_front();
      ref_tag[rq.dest] = exp.new_tag;
      ref_rdy[rq.dest] = 1'b0;
    end
    slot_old[ref_tail] = exp.old_tag;
    slot_new[ref_tail] = exp.new_tag;
    ckpt_tag[ref_tail] = ref_tag;
    ref_tail  = (ref_tail + 1) % `RN_SLOTS;
    ref_count = ref_count + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_event(input rename_event_t ev);
    model_event(ev);
    @(posedge clock);
    event_valid <= 1'b1;
    evt         <= ev;
    @(posedge clock);
    event_valid <= 1'b0; // One cycle only
  endtask

  // Event lands with req, or after a hold in which ack must stay low
  task automatic rename_op(input string name, input rename_req_t rq, input logic with_ev,
                           input rename_event_t ev, input int hold);
    rename_rsp_t exp;
    int          early;
    early = 0;
    if (with_ev) model_event(ev);
    model_rename(rq, exp);
    @(posedge clock);
    request <= rq;
    req     <= 1'b1;
    repeat (hold) begin
      @(negedge clock);
      if (ack) early = early + 1;
    end
    if (early > 0) begin
      n_errors = n_errors + 1;
      $display("%s: ack rose while the rename should have been held back", name);
    end
    if (hold > 0) @(posedge clock);
    if (with_ev) begin
      event_valid <= 1'b1;
      evt         <= ev;
      @(posedge clock);
      event_valid <= 1'b0;
    end
    @(negedge clock);          // Outputs are settled at the falling edge
    while (!ack) @(negedge clock);
    n_checks = n_checks + 1;
    if (response !== exp) begin
      n_errors = n_errors + 1;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, response);
    end
    @(posedge clock);
    req <= 1'b0;
    @(negedge clock);
    while (ack) @(negedge clock);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    int          a;
    int          assert_fails;
    req         = 1'b0;
    request     = '0;
    event_valid = 1'b0;
    evt         = '0;
    foreach (ref_tag[i]) ref_tag[i] = phys_tag_t'(i); // Identity map after reset
    foreach (ref_rdy[i]) ref_rdy[i] = 1'b1;
    for (int i = `RN_ARCH_REGS; i < `RN_PHYS_REGS; i++) free_q.push_back(phys_tag_t'(i));
    ref_head  = 0;
    ref_tail  = 0;
    ref_count = 0;
    wait (reset == 1'b0);

    rename_op("in_order", make_req(3, 1, 2), 1'b0, '0, 0);   // r3 gets 32
    rename_op("in_order", make_req(5, 3, 31), 1'b0, '0, 0);  // Reads r3 not ready
    rename_op("in_order", make_req(3, 3, 5), 1'b0, '0, 0);   // Old tag 32
    rename_op("in_order", make_req(7, 31, 3), 1'b0, '0, 0);
    send_event(make_event(EV_COMPLETE, 3, 32));               // Stale since r3 now holds 34
    rename_op("stale_complete", make_req(8, 3, 31), 1'b0, '0, 0);
    send_event(make_event(EV_COMPLETE, 3, 34));
    rename_op("complete_bypass", make_req(9, 3, 5), 1'b1, make_event(EV_COMPLETE, 5, 33), 0);
    rename_op("rollback", make_req(10, 3, 5), 1'b1, make_event(EV_ROLLBACK, 1, '0), 0);
    for (int d = 11; d < 16; d++) rename_op("fill", make_req(d, d - 1, 10), 1'b0, '0, 0);
    rename_op("slots_full", make_req(16, 10, 15), 1'b1,
              make_event(EV_RETIRE, ref_head, slot_old[ref_head]), STALL_CYCLES);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      r = draw_bits(3);
      if (r[2:0] == 3'd7 && ref_count > 0) begin
        r = draw_bits(3);
        a = (ref_head + int'(r % ref_count)) % `RN_SLOTS; // Any slot still in flight
        send_event(make_event(EV_ROLLBACK, a, '0));
      end else if ((r[2:0] == 3'd6 && ref_count > 0) || ref_count == `RN_SLOTS) begin
        send_event(make_event(EV_RETIRE, ref_head, slot_old[ref_head]));
      end else if (r[2:0] >= 3'd4) begin
        r = draw_bits(6);
        a = (r[5:1] == 5'd31) ? 0 : int'(r[5:1]);
        send_event(make_event(EV_COMPLETE, a, ref_tag[a] ^ phys_tag_t'(r[0]))); // Odd is stale
      end else begin
        r = draw_bits(15);
        rename_op("random", make_req((r[14:10] == 5'd31) ? 0 : int'(r[14:10]),
                  int'(r[9:5]), int'(r[4:0])), 1'b0, '0, 0);
      end
    end

    while (ref_count > 5) send_event(make_event(EV_RETIRE, ref_head, slot_old[ref_head]));
    rename_op("zero_dest", make_req(31, 31, 4), 1'b0, '0, 0);
    rename_op("zero_dest_next", make_req(4, 31, 4), 1'b0, '0, 0); // Free head did not move

    repeat (2) @(posedge clock);
    assert_fails = u_dut.u_asserts.fail_count;
    $display("Checks: %0d, response errors: %0d, assertion failures: %0d",
             n_checks, n_errors, assert_fails);
    if (n_errors == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- rename_top.sv
// Register-rename stage top level
// Controller, slot counter, map table and free list wired together

`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     req,
  input  rename_pkg::rename_req_t   request,
  output logic                     ack,
  output rename_pkg::rename_rsp_t   response,
  input  logic                     event_valid,
  input  rename_pkg::rename_event_t evt
);
  import rename_pkg::*;

  logic       rename_fire;
  logic       free_empty;
  logic       slots_full;
  logic       dest_is_zero;
  phys_tag_t  free_tag;
  phys_tag_t  old_tag;
  slot_idx_t  tail_slot;
  map_entry_t lookup_a;
  map_entry_t lookup_b;

  assign dest_is_zero = request.dest == arch_idx_t'(`RN_ZERO_REG);

  rename_ctrl u_ctrl (
    .clock, .reset, .req, .request, .event_valid, .evt,
    .free_empty, .slots_full, .lookup_a, .lookup_b, .old_tag, .free_tag,
    .tail_slot, .rename_fire, .ack, .response
  );

  rob_slot_counter u_slots (
    .clock, .reset, .rename_fire, .event_valid, .evt,
    .tail_slot, .slots_full
  );

  free_list u_free (
    .clock, .reset, .rename_fire, .dest_is_zero, .event_valid, .evt,
    .tail_slot, .free_tag, .free_empty
  );

  map_table u_map (
    .clock, .reset, .request, .rename_fire, .free_tag, .tail_slot,
    .event_valid, .evt, .lookup_a, .lookup_b, .old_tag
  );

endmodule

//--- rob_slot_counter.sv
// Reorder-buffer slot numbering with head, tail and occupancy
// Rename takes the tail slot, retire frees the head, rollback cuts the tail

`timescale 1ns/1ps
`include "rename_macros.svh"

module rob_slot_counter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     rename_fire,
  input  logic                     event_valid,
  input  rename_pkg::rename_event_t evt,
  output rename_pkg::slot_idx_t     tail_slot,
  output logic                     slots_full
);
  import rename_pkg::*;

  localparam int CNT_W = $clog2(`RN_SLOTS) + 1;

  slot_idx_t        head_q;  // Oldest slot in flight
  slot_idx_t        tail_q;  // Slot the next rename takes
  logic [CNT_W-1:0] count_q; // Slots in flight
  slot_idx_t        keep_span;

  logic retire;
  logic rollback;

  assign retire   = event_valid && (evt.kind == EV_RETIRE);
  assign rollback = event_valid && (evt.kind == EV_ROLLBACK);

  // The rollback slot stays live, so it and everything older down to the head remain
  assign keep_span = evt.body.recover.slot - head_q;

  assign tail_slot  = tail_q;
  assign slots_full = count_q == CNT_W'(`RN_SLOTS);

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (rollback) begin
      tail_q  <= evt.body.recover.slot + 1'b1;   // One past the surviving slot
      count_q <= CNT_W'(keep_span) + 1'b1;        // Range 1 to 8, never zero
    end else begin
      if (rename_fire) tail_q <= tail_q + 1'b1;
      if (retire)      head_q <= head_q + 1'b1;
      case ({rename_fire, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;             // Both or neither leave it as is
      endcase
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the rename testbench with Verilator, run it and search the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -Wno-fatal --top-module rename_tb -f flist.f -o rename_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/rename_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1

//--- tb_clock.sv
// Testbench clock and reset generator
// 10 ns clock and a synchronous reset held for a set number of cycles

`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 16 // Rising edges with reset high
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock; // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0; // Released on a rising edge like every other input
  end

endmodule
